/* Bender.yml */
package:
  name: merge_node

sources:
  - files:
      - logic/merge_data_pkg.sv
      - logic/merge_ctrl_pkg.sv
      - logic/merge_fifo.sv
      - logic/merge_select.sv
      - logic/merge_control.sv
      - logic/merge_node.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_merge_node.sv

/* logic/merge_control.sv */
`timescale 1ns/10ps
`default_nettype none

module merge_control
   import merge_ctrl_pkg::*;
(
   input  wire               i_clk,
   input  wire               i_arst_n,
   input  wire head_status_t i_status,
   input  wire               i_out_full,
   input  wire               i_end,
   output merge_cmd_t        o_cmd,
   output logic              o_done
);

   merge_state_e state;
   merge_state_e next_state;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= NOMINAL;
      end else begin
         state <= next_state;
      end
   end

   // commands and next state, both taken at the same edge.
   always_comb begin
      next_state = state;
      o_cmd      = '0;
      case (state)
         NOMINAL: begin
            if (i_status.a_zero) begin
               next_state = DONE_A; // a's run ended, no push.
            end else if (i_status.b_zero) begin
               next_state = DONE_B;
            end else if (i_status.a_valid && i_status.b_valid) begin
               if (!i_out_full) begin
                  o_cmd.push  = 1'b1;
                  o_cmd.sel_a = i_status.a_lte_b;
                  o_cmd.pop_a = i_status.a_lte_b;
                  o_cmd.pop_b = ~i_status.a_lte_b;
               end
            end else if (!i_status.a_valid && !i_status.b_valid && i_end) begin
               next_state = FINISHED;
            end
         end
         DONE_A: begin
            // drain the rest of b's run.
            if (i_status.b_zero) begin
               next_state = TOGGLE;
            end else if (i_status.b_valid && !i_out_full) begin
               o_cmd.push  = 1'b1;
               o_cmd.pop_b = 1'b1;
            end
         end
         DONE_B: begin
            if (i_status.a_zero) begin
               next_state = TOGGLE;
            end else if (i_status.a_valid && !i_out_full) begin
               o_cmd.push  = 1'b1;
               o_cmd.pop_a = 1'b1;
               o_cmd.sel_a = 1'b1;
            end
         end
         TOGGLE: begin
            // drop both terminators, emit one.
            if (i_status.a_zero && i_status.b_zero && !i_out_full) begin
               o_cmd.push  = 1'b1;
               o_cmd.pop_a = 1'b1;
               o_cmd.pop_b = 1'b1;
               next_state  = NOMINAL;
            end
         end
         FINISHED: begin
            next_state = FINISHED;
         end
         default: begin
            next_state = NOMINAL;
         end
      endcase
   end

   assign o_done = (state == FINISHED);

   a_pop_valid: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (o_cmd.pop_a |-> i_status.a_valid) and (o_cmd.pop_b |-> i_status.b_valid)
   ) else $error("merge_control: pop on a missing head");

   a_no_push_full: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      o_cmd.push |-> !i_out_full
   ) else $error("merge_control: push while output full");

   a_finished_sticky: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (state == FINISHED) |=> (state == FINISHED)
   ) else $error("merge_control: left FINISHED");

endmodule

`default_nettype wire

/* logic/merge_ctrl_pkg.sv */
`default_nettype none

package merge_ctrl_pkg;

   typedef enum logic [2:0] {
      NOMINAL  = 3'b000,
      TOGGLE   = 3'b001,
      DONE_A   = 3'b010,
      DONE_B   = 3'b011,
      FINISHED = 3'b100
   } merge_state_e;

   // head status seen by the controller.
   // zero flags are only set for a valid head.
   typedef struct packed {
      logic a_valid;
      logic b_valid;
      logic a_zero;
      logic b_zero;
      logic a_lte_b;
   } head_status_t;

   // one command per cycle.
   typedef struct packed {
      logic pop_a;
      logic pop_b;
      logic push;
      logic sel_a; // pushed word is a's head.
   } merge_cmd_t;

endpackage

`default_nettype wire

/* logic/merge_data_pkg.sv */
`default_nettype none

package merge_data_pkg;

   // data word, zero is the run terminator.
   localparam int DATA_W = 16;
   typedef logic [DATA_W-1:0] word_t;

   // fifo geometry, depth must be a power of two.
   localparam int FIFO_DEPTH = 8;
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam int LEVEL_W    = $clog2(FIFO_DEPTH + 1);

   typedef logic [PTR_W-1:0]   ptr_t;
   typedef logic [LEVEL_W-1:0] level_t;

   // completed-run counter.
   localparam int RUN_CNT_W = 8;
   typedef logic [RUN_CNT_W-1:0] run_cnt_t;

endpackage

`default_nettype wire

/* logic/merge_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module merge_fifo
   import merge_data_pkg::*;
(
   input  wire        i_clk,
   input  wire        i_arst_n,
   input  wire        i_wr,
   input  wire word_t i_data,
   input  wire        i_rd,
   output word_t      o_data,
   output logic       o_full,
   output logic       o_empty,
   output level_t     o_level
);

   word_t  mem [FIFO_DEPTH];
   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   level_t count;
   logic   do_wr;
   logic   do_rd;

   assign o_full  = (count == level_t'(FIFO_DEPTH));
   assign o_empty = (count == '0);
   assign o_level = count;

   assign do_wr = i_wr & ~o_full;
   assign do_rd = i_rd & ~o_empty;

   // show-ahead head.
   assign o_data = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // callers watch o_full and o_empty.
   a_no_write_full: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      i_wr |-> !o_full
   ) else $error("merge_fifo: write while full");

   a_no_read_empty: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      i_rd |-> !o_empty
   ) else $error("merge_fifo: read while empty");

endmodule

`default_nettype wire

/* logic/merge_node.sv */
`timescale 1ns/10ps
`default_nettype none

module merge_node
   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;
(
   input  wire        i_clk,
   input  wire        i_arst_n,
   input  wire        i_a_wr,
   input  wire word_t i_a_data,
   input  wire        i_b_wr,
   input  wire word_t i_b_data,
   input  wire        i_end,
   input  wire        i_out_rd,
   output logic       o_a_full,
   output logic       o_b_full,
   output logic       o_out_valid,
   output word_t      o_out_data,
   output run_cnt_t   o_runs,
   output logic       o_done
);

   word_t        a_head;
   word_t        b_head;
   logic         a_empty;
   logic         b_empty;
   logic         out_full;
   logic         out_empty;
   word_t        out_word;
   head_status_t status;
   merge_cmd_t   cmd;

   assign o_out_valid = ~out_empty;

   merge_fifo u_fifo_a (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_wr     (i_a_wr),
      .i_data   (i_a_data),
      .i_rd     (cmd.pop_a),
      .o_data   (a_head),
      .o_full   (o_a_full),
      .o_empty  (a_empty),
      .o_level  ()
   );

   merge_fifo u_fifo_b (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_wr     (i_b_wr),
      .i_data   (i_b_data),
      .i_rd     (cmd.pop_b),
      .o_data   (b_head),
      .o_full   (o_b_full),
      .o_empty  (b_empty),
      .o_level  ()
   );

   merge_select u_select (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_a_head   (a_head),
      .i_b_head   (b_head),
      .i_a_empty  (a_empty),
      .i_b_empty  (b_empty),
      .i_cmd      (cmd),
      .o_status   (status),
      .o_out_word (out_word),
      .o_runs     (o_runs)
   );

   merge_control u_control (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_status   (status),
      .i_out_full (out_full),
      .i_end      (i_end),
      .o_cmd      (cmd),
      .o_done     (o_done)
   );

   // merged runs with their terminators.
   merge_fifo u_fifo_out (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_wr     (cmd.push),
      .i_data   (out_word),
      .i_rd     (i_out_rd),
      .o_data   (o_out_data),
      .o_full   (out_full),
      .o_empty  (out_empty),
      .o_level  ()
   );

endmodule

`default_nettype wire

/* logic/merge_select.sv */
`timescale 1ns/10ps
`default_nettype none

module merge_select
   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;
(
   input  wire             i_clk,
   input  wire             i_arst_n,
   input  wire word_t      i_a_head,
   input  wire word_t      i_b_head,
   input  wire             i_a_empty,
   input  wire             i_b_empty,
   input  wire merge_cmd_t i_cmd,
   output head_status_t    o_status,
   output word_t           o_out_word,
   output run_cnt_t        o_runs
);

   logic     a_valid;
   logic     b_valid;
   logic     terminator;
   run_cnt_t run_cnt;

   assign a_valid = ~i_a_empty;
   assign b_valid = ~i_b_empty;

   // head status, stale words behind an empty fifo are masked.
   always_comb begin
      o_status.a_valid = a_valid;
      o_status.b_valid = b_valid;
      o_status.a_zero  = a_valid && (i_a_head == '0);
      o_status.b_zero  = b_valid && (i_b_head == '0);
      o_status.a_lte_b = (i_a_head <= i_b_head); // tie goes to a.
   end

   // both pops with a push closes a run.
   assign terminator = i_cmd.push & i_cmd.pop_a & i_cmd.pop_b;

   always_comb begin
      if (terminator) begin
         o_out_word = '0;
      end else if (i_cmd.sel_a) begin
         o_out_word = i_a_head;
      end else begin
         o_out_word = i_b_head;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         run_cnt <= '0;
      end else if (terminator) begin
         run_cnt <= run_cnt + 1'b1;
      end
   end

   assign o_runs = run_cnt;

   // the controller only closes a run on two zero heads.
   a_term_on_zero_heads: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      terminator |-> (o_status.a_zero && o_status.b_zero)
   ) else $error("merge_select: terminator without two zero heads");

   // a data push never carries a zero word.
   a_no_zero_data: assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (i_cmd.push && !terminator) |-> (o_out_word != '0)
   ) else $error("merge_select: zero word pushed inside a run");

endmodule

`default_nettype wire

/* test/merge_node_checks.svh */
int unsigned value_errs = 0;
int unsigned other_errs = 0;

// staging runs, input streams and expected output.
word_t       run_a[$];
word_t       run_b[$];
word_t       a_stream[$];
word_t       b_stream[$];
word_t       exp_out[$];
int unsigned exp_runs = 0;

// merges one run pair into the expected output, then clears the staging runs.
task automatic model_pair();
   int ia;
   int ib;
   ia = 0;
   ib = 0;
   foreach (run_a[i]) a_stream.push_back(run_a[i]);
   foreach (run_b[i]) b_stream.push_back(run_b[i]);
   a_stream.push_back('0);
   b_stream.push_back('0);
   while (ia < run_a.size() || ib < run_b.size()) begin
      if (ib >= run_b.size() || (ia < run_a.size() && run_a[ia] <= run_b[ib])) begin
         exp_out.push_back(run_a[ia]); // a wins a tie.
         ia++;
      end else begin
         exp_out.push_back(run_b[ib]);
         ib++;
      end
   end
   exp_out.push_back('0);
   exp_runs++;
   run_a.delete();
   run_b.delete();
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
   if (got !== exp) begin
      value_errs++;
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
   end
endtask

task automatic check_runs(input string name, input run_cnt_t got, input run_cnt_t exp);
   if (got !== exp) begin
      value_errs++;
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      value_errs++;
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
   end
endtask

/* test/tb_merge_node.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_merge_node
   import merge_data_pkg::*;
;

   logic     i_clk;
   logic     i_arst_n;
   logic     i_a_wr;
   word_t    i_a_data;
   logic     i_b_wr;
   word_t    i_b_data;
   logic     i_end;
   logic     i_out_rd;
   logic     o_a_full;
   logic     o_b_full;
   logic     o_out_valid;
   word_t    o_out_data;
   run_cnt_t o_runs;
   logic     o_done;

   int unsigned cycle_cnt     = 0;
   int unsigned words_written = 0;

   `include "merge_node_checks.svh"

   merge_node UUT (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_a_wr      (i_a_wr),
      .i_a_data    (i_a_data),
      .i_b_wr      (i_b_wr),
      .i_b_data    (i_b_data),
      .i_end       (i_end),
      .i_out_rd    (i_out_rd),
      .o_a_full    (o_a_full),
      .o_b_full    (o_b_full),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data),
      .o_runs      (o_runs),
      .o_done      (o_done)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   // limit grows with the words written so far.
   always @(posedge i_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > 200 + 20 * words_written) begin
         other_errs++;
         $display("timeout, no progress after %0d cycles", cycle_cnt);
         $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // writes one input stream, waiting out a full fifo.
   task automatic feed_stream(input bit to_b, input bit gaps);
      int    n;
      int    i;
      word_t w;
      n = to_b ? b_stream.size() : a_stream.size();
      for (i = 0; i < n; i++) begin
         w = to_b ? b_stream[i] : a_stream[i];
         if (gaps) repeat ($urandom_range(0, 3)) @(negedge i_clk);
         @(negedge i_clk);
         while (to_b ? o_b_full : o_a_full) @(negedge i_clk);
         if (to_b) begin
            i_b_wr   = 1'b1;
            i_b_data = w;
         end else begin
            i_a_wr   = 1'b1;
            i_a_data = w;
         end
         words_written++;
         @(negedge i_clk);
         if (to_b) i_b_wr = 1'b0;
         else i_a_wr = 1'b0;
      end
   endtask

   // writes one fifo depth of words from the front of one stream, back to back.
   task automatic fill_input(input bit to_b);
      int i;
      for (i = 0; i < FIFO_DEPTH; i++) begin
         @(negedge i_clk);
         if (to_b) begin
            i_b_wr   = 1'b1;
            i_b_data = b_stream.pop_front();
         end else begin
            i_a_wr   = 1'b1;
            i_a_data = a_stream.pop_front();
         end
         words_written++;
      end
      @(negedge i_clk);
      i_a_wr = 1'b0;
      i_b_wr = 1'b0;
   endtask

   // pops and checks every expected word. stall holds reads off, then reads at random.
   task automatic drain_output(input bit stall);
      int    hold;
      word_t want;
      hold = stall ? 40 : 0;
      while (exp_out.size() > 0) begin
         @(negedge i_clk);
         i_out_rd = 1'b0;
         if (hold > 0) begin
            hold--;
         end else if (o_out_valid && (!stall || $urandom_range(0, 1) == 1)) begin
            want = exp_out.pop_front();
            check_word("o_out_data", o_out_data, want);
            i_out_rd = 1'b1;
         end
      end
      @(negedge i_clk);
      i_out_rd = 1'b0;
   endtask

   task automatic run_streams(input bit gaps, input bit stall);
      fork
         feed_stream(1'b0, gaps);
         feed_stream(1'b1, gaps);
         drain_output(stall);
      join
      a_stream.delete();
      b_stream.delete();
      repeat (3) @(negedge i_clk);
      check_flag("o_out_valid", o_out_valid, 1'b0); // nothing left over.
      check_runs("o_runs", o_runs, run_cnt_t'(exp_runs));
   endtask

   task automatic test_reset_values();
      check_flag("o_out_valid", o_out_valid, 1'b0);
      check_flag("o_done", o_done, 1'b0);
      check_runs("o_runs", o_runs, '0);
   endtask

   task automatic test_single_pair();
      run_a = '{3, 8, 12, 40};
      run_b = '{1, 9, 10, 41, 50};
      model_pair();
      run_streams(1'b0, 1'b0);
   endtask

   task automatic test_uneven_runs();
      run_a = '{2, 4, 6, 8, 10, 12, 14, 16, 18};
      run_b = '{5, 7};
      model_pair();
      run_b = '{11, 13, 17}; // a's run is empty.
      model_pair();
      run_a = '{21, 22, 23, 24}; // b's run is empty.
      model_pair();
      run_streams(1'b0, 1'b0);
   endtask

   task automatic test_ties_backpressure();
      run_a = '{5, 9, 9, 20, 30, 31};
      run_b = '{5, 9, 20, 20, 25, 40, 41};
      model_pair();
      run_streams(1'b0, 1'b1);
   endtask

   // one side waits for a head on the other, so its fifo fills.
   task automatic test_input_full();
      int side;
      int i;
      for (side = 0; side < 2; side++) begin
         for (i = 1; i <= FIFO_DEPTH; i++) begin
            if (side == 0) run_a.push_back(word_t'(3 * i));
            else run_b.push_back(word_t'(3 * i));
         end
         if (side == 0) run_b = '{4, 10};
         else run_a = '{4, 10};
         model_pair();
         fill_input(side == 1);
         check_flag("o_a_full", o_a_full, side == 0);
         check_flag("o_b_full", o_b_full, side == 1);
         run_streams(1'b0, 1'b0);
      end
   endtask

   task automatic test_random_streams();
      int    k;
      int    j;
      word_t v;
      for (k = 0; k < 5; k++) begin
         v = word_t'($urandom_range(1, 40));
         repeat ($urandom_range(0, 6)) begin
            run_a.push_back(v);
            v = v + word_t'(1 + $urandom_range(0, 30));
         end
         v = word_t'($urandom_range(1, 40));
         for (j = $urandom_range(0, 6); j > 0; j--) begin
            run_b.push_back(v);
            v = v + word_t'(1 + $urandom_range(0, 30));
         end
         model_pair();
      end
      run_streams(1'b1, 1'b0);
      @(negedge i_clk);
      i_end = 1'b1;
      j = 0;
      while (!o_done && j < 50) begin
         @(negedge i_clk);
         j++;
      end
      check_flag("o_done", o_done, 1'b1);
   endtask

   initial begin
      i_arst_n = 1'b0;
      i_a_wr   = 1'b0;
      i_a_data = '0;
      i_b_wr   = 1'b0;
      i_b_data = '0;
      i_end    = 1'b0;
      i_out_rd = 1'b0;
      void'($urandom(94555));
      repeat (8) @(posedge i_clk);
      @(negedge i_clk);
      i_arst_n = 1'b1;

      test_reset_values();
      test_single_pair();
      test_uneven_runs();
      test_ties_backpressure();
      test_input_full();
      test_random_streams();

      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
logic/merge_data_pkg.sv
logic/merge_ctrl_pkg.sv
logic/merge_fifo.sv
logic/merge_select.sv
logic/merge_control.sv
logic/merge_node.sv
test/tb_merge_node.sv
